//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mul16 \
		-f project.f -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_mul16); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- bench/tb_mul16.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module tb_mul16
    import mul_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int DRAIN_CYCLES    = 8;
    localparam int EDGE_VECTORS    = 32;  // zero and one against random values
    localparam int POW2_VECTORS    = `MUL_OPERAND_W * `MUL_OPERAND_W;
    localparam int PATTERN_VECTORS = 16;
    localparam int STREAM_VECTORS  = 200;
    localparam int GAPPED_VECTORS  = 200;
    localparam int HALF_VECTORS    = 102;
    localparam int NUM_VECTORS     = EDGE_VECTORS + POW2_VECTORS + PATTERN_VECTORS
                                   + STREAM_VECTORS + GAPPED_VECTORS + HALF_VECTORS;
    localparam int WATCHDOG_NS     = (NUM_VECTORS + RESET_CYCLES + DRAIN_CYCLES)
                                   * CLK_PERIOD * 2;

    logic     clk;
    logic     rst;
    operand_t a;
    operand_t b;
    logic     in_valid;
    product_t product;
    logic     out_valid;

    logic [31:0] rng_state;
    string       current_test;
    string       test_name;  // name attached to the pair on the bus

    product_t   exp_q [$];
    string      name_q [$];
    logic [2:0] valid_shadow;  // in_valid history with oldest in bit 2
    logic       exp_valid = 1'b0;
    product_t   exp_product;
    string      exp_name;
    int         reset_edges     = 0;
    int         value_errors    = 0;
    int         protocol_errors = 0;

    mul16_pipe u_dut (
        .clk       (clk),
        .rst       (rst),
        .a         (a),
        .b         (b),
        .in_valid  (in_valid),
        .product   (product),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic operand_t next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];  // low bits repeat too soon
    endfunction

    function automatic product_t exact_product(operand_t x, operand_t y);
        return product_t'(x) * product_t'(y);
    endfunction

    task automatic drive_pair(input operand_t x, input operand_t y, input logic v);
        @(negedge clk);
        a         = x;
        b         = y;
        in_valid  = v;
        test_name = current_test;
    endtask

    // expected results enter when the DUT samples a pair
    always @(posedge clk) begin
        if (rst) begin
            valid_shadow <= '0;
            reset_edges  <= reset_edges + 1;
        end else begin
            valid_shadow <= {valid_shadow[1:0], in_valid};
            if (in_valid) begin
                exp_q.push_back(exact_product(a, b));
                name_q.push_back(test_name);
            end
        end
    end

    // expected output for the next rising edge
    always @(negedge clk) begin
        exp_valid = valid_shadow[2];
        if (valid_shadow[2]) begin
            exp_product = exp_q.pop_front();
            exp_name    = name_q.pop_front();
        end
    end

    reset_keeps_valid_low: assert property (
        @(posedge clk) (rst && reset_edges > 0) |-> !out_valid)
    else begin
        protocol_errors++;
        $display("out_valid was high while reset was held at %0t", $time);
    end

    valid_follows_input: assert property (
        @(posedge clk) disable iff (rst) out_valid == exp_valid)
    else begin
        protocol_errors++;
        $display("out_valid is %b but in_valid two cycles earlier was %b at %0t",
                 $sampled(out_valid), exp_valid, $time);
    end

    product_matches: assert property (
        @(posedge clk) disable iff (rst) (out_valid && exp_valid) |-> product == exp_product)
    else begin
        value_errors++;
        $display("Mismatch %s: expected %h, actual %h",
                 exp_name, exp_product, $sampled(product));
    end

    task automatic corner_products();
        operand_t r;
        operand_t patterns [4];
        patterns[0] = 16'hAAAA;
        patterns[1] = 16'h5555;
        patterns[2] = 16'hFFFF;
        patterns[3] = 16'h0000;
        current_test = "zero_and_one";
        for (int i = 0; i < EDGE_VECTORS / 4; i++) begin
            r = next_rand();
            drive_pair(16'd0, r, 1'b1);
            drive_pair(r, 16'd0, 1'b1);
            drive_pair(16'd1, r, 1'b1);
            drive_pair(r, 16'd1, 1'b1);
        end
        current_test = "powers_of_two";
        for (int i = 0; i < `MUL_OPERAND_W; i++) begin
            for (int j = 0; j < `MUL_OPERAND_W; j++) begin
                drive_pair(operand_t'(1) << i, operand_t'(1) << j, 1'b1);
            end
        end
        current_test = "bit_patterns";  // includes ffff * ffff
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                drive_pair(patterns[i], patterns[j], 1'b1);
            end
        end
    endtask

    task automatic back_to_back_stream();
        current_test = "back_to_back";
        for (int i = 0; i < STREAM_VECTORS; i++) begin
            drive_pair(next_rand(), next_rand(), 1'b1);
        end
    endtask

    task automatic gapped_stream();
        operand_t r;
        current_test = "gapped";
        for (int i = 0; i < GAPPED_VECTORS; i++) begin
            r = next_rand();
            drive_pair(next_rand(), next_rand(), r[0]);
        end
    endtask

    task automatic half_isolation();
        operand_t r;
        current_test = "low_byte_only";
        for (int i = 0; i < 50; i++) begin
            r = next_rand();
            drive_pair(r & 16'h00FF, next_rand(), 1'b1);
        end
        current_test = "high_byte_only";  // hi rows shifted by one byte
        for (int i = 0; i < 50; i++) begin
            r = next_rand();
            drive_pair(r & 16'hFF00, next_rand(), 1'b1);
        end
        current_test = "carry_chain";
        drive_pair(16'h00FF, 16'hFFFF, 1'b1);
        drive_pair(16'hFF00, 16'hFFFF, 1'b1);
    endtask

    initial begin
        rng_state    = 32'd23;
        rst          = 1'b1;
        a            = '0;
        b            = '0;
        in_valid     = 1'b0;
        current_test = "reset";
        test_name    = "reset";

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        corner_products();
        back_to_back_stream();
        gapped_stream();
        half_isolation();

        current_test = "drain";
        repeat (DRAIN_CYCLES) drive_pair('0, '0, 1'b0);

        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // twice the expected run time
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/mul_pkg.sv
source/row_pkg.sv
source/kogge_stone_adder.sv
source/pp_half_reduce.sv
source/mul_combine.sv
source/mul16_pipe.sv
bench/tb_mul16.sv

//--- source/kogge_stone_adder.sv
`timescale 1ns/1ps
`default_nettype none

module kogge_stone_adder #(
    parameter int WIDTH = 32
) (
    input  wire  [WIDTH-1:0] a,
    input  wire  [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum
);

    localparam int LEVELS = $clog2(WIDTH);

    // group generate / propagate after each prefix level
    wire [WIDTH-1:0] g_lvl [0:LEVELS];
    wire [WIDTH-1:0] p_lvl [0:LEVELS];

    assign g_lvl[0] = a & b;
    assign p_lvl[0] = a ^ b;

    genvar k;
    genvar i;
    generate
        for (k = 1; k <= LEVELS; k++) begin : g_level
            localparam int SPAN = 1 << (k - 1);

            for (i = 0; i < WIDTH; i++) begin : g_bit
                if (i < SPAN) begin : g_pass
                    // already resolved down to bit 0
                    assign g_lvl[k][i] = g_lvl[k-1][i];
                    assign p_lvl[k][i] = p_lvl[k-1][i];
                end else if (i < 2 * SPAN) begin : g_gray
                    // group reaches bit 0 here, generate only
                    assign g_lvl[k][i] = g_lvl[k-1][i]
                                       | (p_lvl[k-1][i] & g_lvl[k-1][i-SPAN]);
                    assign p_lvl[k][i] = p_lvl[k-1][i];
                end else begin : g_black
                    assign g_lvl[k][i] = g_lvl[k-1][i]
                                       | (p_lvl[k-1][i] & g_lvl[k-1][i-SPAN]);
                    assign p_lvl[k][i] = p_lvl[k-1][i] & p_lvl[k-1][i-SPAN];
                end
            end
        end
    endgenerate

    // carry into bit i is the prefix generate of bit i-1, no carry-in
    assign sum = p_lvl[0] ^ {g_lvl[LEVELS][WIDTH-2:0], 1'b0};

endmodule

`default_nettype wire

//--- source/mul16_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mul16_pipe
    import mul_pkg::*;
    import row_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire operand_t a,
    input  wire operand_t b,
    input  wire           in_valid,
    output product_t      product,
    output logic          out_valid
);

    operand_t a_q;
    operand_t b_q;
    logic     v1;
    logic     v2;

    slice_t a_lo;
    slice_t a_hi;

    half_row_t lo_sum;
    half_row_t lo_carry;
    half_row_t hi_sum;
    half_row_t hi_carry;

    product_t comb_product;

    // operand register, no reset on data
    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
    end

    assign {a_hi, a_lo} = a_q;

    pp_half_reduce u_lo (
        .clk       (clk),
        .a_slice   (a_lo),
        .b         (b_q),
        .sum_row   (lo_sum),
        .carry_row (lo_carry)
    );

    pp_half_reduce u_hi (
        .clk       (clk),
        .a_slice   (a_hi),
        .b         (b_q),
        .sum_row   (hi_sum),
        .carry_row (hi_carry)
    );

    mul_combine u_comb (
        .lo_sum   (lo_sum),
        .lo_carry (lo_carry),
        .hi_sum   (hi_sum),
        .hi_carry (hi_carry),
        .product  (comb_product)
    );

    always_ff @(posedge clk) begin
        product <= comb_product;
    end

    // valid follows data through the three register stages
    always_ff @(posedge clk) begin
        if (rst) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            v1        <= in_valid;
            v2        <= v1;
            out_valid <= v2;
        end
    end

endmodule

`default_nettype wire

//--- source/mul_combine.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_combine
    import mul_pkg::*;
    import row_pkg::*;
(
    input  wire half_row_t lo_sum,
    input  wire half_row_t lo_carry,
    input  wire half_row_t hi_sum,
    input  wire half_row_t hi_carry,
    output product_t       product
);

    function automatic full_row_t csa_sum(full_row_t x, full_row_t y, full_row_t z);
        return x ^ y ^ z;
    endfunction

    function automatic full_row_t csa_carry(full_row_t x, full_row_t y, full_row_t z);
        return ((x & y) | (x & z) | (y & z)) << 1;
    endfunction

    full_row_t row_lo_s;
    full_row_t row_lo_c;
    full_row_t row_hi_s;
    full_row_t row_hi_c;
    full_row_t s1;
    full_row_t c1;
    full_row_t s2;
    full_row_t c2;

    // lo rows sit at weight 1, hi rows at 2^8
    assign row_lo_s = full_row_t'(lo_sum);
    assign row_lo_c = full_row_t'(lo_carry);
    assign row_hi_s = full_row_t'(hi_sum) << `MUL_SLICE_W;
    assign row_hi_c = full_row_t'(hi_carry) << `MUL_SLICE_W;

    // four rows down to two
    assign s1 = csa_sum(row_lo_s, row_lo_c, row_hi_s);
    assign c1 = csa_carry(row_lo_s, row_lo_c, row_hi_s);
    assign s2 = csa_sum(s1, c1, row_hi_c);
    assign c2 = csa_carry(s1, c1, row_hi_c);

    kogge_stone_adder #(
        .WIDTH (`MUL_PRODUCT_W)
    ) u_ks (
        .a   (s2),
        .b   (c2),
        .sum (product)
    );

endmodule

`default_nettype wire

//--- source/mul_consts.svh
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// operand width, both A and B
`define MUL_OPERAND_W 16

// A is handled one byte per half
`define MUL_SLICE_W 8

`define MUL_PRODUCT_W (2 * `MUL_OPERAND_W)

// one half's rows hold slice * B exactly
`define MUL_HALF_ROW_W (`MUL_SLICE_W + `MUL_OPERAND_W)

`endif

//--- source/mul_pkg.sv
`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

    // boundary types of the multiplier
    typedef logic [`MUL_OPERAND_W-1:0] operand_t;

    typedef logic [`MUL_SLICE_W-1:0] slice_t;   // one byte of A

    typedef logic [`MUL_PRODUCT_W-1:0] product_t;

endpackage

`default_nettype wire

//--- source/pp_half_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module pp_half_reduce
    import mul_pkg::*;
    import row_pkg::*;
(
    input  wire           clk,
    input  wire slice_t   a_slice,
    input  wire operand_t b,
    output half_row_t     sum_row,
    output half_row_t     carry_row
);

    localparam int NUM_PP = $bits(slice_t);

    // word-level 3:2 compressor
    function automatic half_row_t csa_sum(half_row_t x, half_row_t y, half_row_t z);
        return x ^ y ^ z;
    endfunction

    function automatic half_row_t csa_carry(half_row_t x, half_row_t y, half_row_t z);
        return ((x & y) | (x & z) | (y & z)) << 1;
    endfunction

    half_row_t pp [0:NUM_PP-1];

    half_row_t s1a;
    half_row_t c1a;
    half_row_t s1b;
    half_row_t c1b;
    half_row_t s2a;
    half_row_t c2a;
    half_row_t s2b;
    half_row_t c2b;
    half_row_t s3;
    half_row_t c3;
    half_row_t s4;
    half_row_t c4;

    always_comb begin
        for (int i = 0; i < NUM_PP; i++) begin
            pp[i] = a_slice[i] ? (half_row_t'(b) << i) : '0;  // b weighted by bit i
        end
    end

    // 8 rows to 6
    assign s1a = csa_sum(pp[0], pp[1], pp[2]);
    assign c1a = csa_carry(pp[0], pp[1], pp[2]);
    assign s1b = csa_sum(pp[3], pp[4], pp[5]);
    assign c1b = csa_carry(pp[3], pp[4], pp[5]);

    // 6 to 4
    assign s2a = csa_sum(s1a, c1a, s1b);
    assign c2a = csa_carry(s1a, c1a, s1b);
    assign s2b = csa_sum(c1b, pp[6], pp[7]);
    assign c2b = csa_carry(c1b, pp[6], pp[7]);

    // 4 to 3
    assign s3 = csa_sum(s2a, c2a, s2b);
    assign c3 = csa_carry(s2a, c2a, s2b);

    // 3 to 2, carry out of bit 23 is always zero
    assign s4 = csa_sum(s3, c3, c2b);
    assign c4 = csa_carry(s3, c3, c2b);

    always_ff @(posedge clk) begin
        sum_row   <= s4;
        carry_row <= c4;
    end

endmodule

`default_nettype wire

//--- source/row_pkg.sv
`default_nettype none

`include "mul_consts.svh"

package row_pkg;

    // sum or carry row leaving one half
    typedef logic [`MUL_HALF_ROW_W-1:0] half_row_t;

    // rows after alignment in the combiner
    typedef logic [`MUL_PRODUCT_W-1:0] full_row_t;

endpackage

`default_nettype wire
